/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing
TOP      := exe_tb
FILELIST := tb.f
PASS_MSG := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* tb.f */
+incdir+verilog
+incdir+tests
verilog/exe_pkg.sv
verilog/exe_pipe_ctrl.sv
verilog/exe_alu.sv
verilog/exe_addr_xlate.sv
verilog/exe_mem_req.sv
verilog/exe_stage.sv
tests/exe_tb.sv

/* tests/exe_tb_table.svh */
`ifndef EXE_TB_TABLE_SVH
`define EXE_TB_TABLE_SVH

// alu_row columns are op, src1 from pc, src2 from imm, operand 1, operand 2, result
// mem_row columns are crmd mode, size, store, vaddr, rkd, paddr, wstrb, wdata, {ale, tlbr, skip}
task automatic build_table();
    alu_row(`EXE_ALU_ADD, 1, 1, 32'h1c000000, 32'h00000010, 32'h1c000010);
    alu_row(`EXE_ALU_SUB, 0, 0, 32'h00000005, 32'h00000007, 32'hfffffffe);
    alu_row(`EXE_ALU_SLT, 0, 0, 32'hffffffff, 32'h00000001, 32'h00000001);
    alu_row(`EXE_ALU_SLTU, 0, 0, 32'hffffffff, 32'h00000001, 32'h00000000);
    alu_row(`EXE_ALU_AND, 0, 0, 32'hf0f0ff00, 32'h0ff0f0f0, 32'h00f0f000);
    alu_row(`EXE_ALU_NOR, 0, 0, 32'hf0f0ff00, 32'h0ff0f0f0, 32'h000f000f);
    alu_row(`EXE_ALU_OR, 0, 0, 32'hf0f0ff00, 32'h0ff0f0f0, 32'hfff0fff0);
    alu_row(`EXE_ALU_XOR, 0, 0, 32'hf0f0ff00, 32'h0ff0f0f0, 32'hff000ff0);
    alu_row(`EXE_ALU_SLL, 0, 1, 32'h00000001, 32'h00000024, 32'h00000010);  // Only low 5 bits
    alu_row(`EXE_ALU_SRL, 0, 0, 32'h80000000, 32'h0000001f, 32'h00000001);
    alu_row(`EXE_ALU_SRA, 0, 0, 32'h80000000, 32'h00000004, 32'hf8000000);
    alu_row(`EXE_ALU_LUI, 0, 1, 32'h0000dead, 32'h12345000, 32'h12345000);
    mem_row(0, 0, 1, 32'h1000, 32'ha1b2c3d4, 32'h1000, 4'b0001, 32'hd4d4d4d4, 3'b000);
    mem_row(0, 0, 1, 32'h1001, 32'ha1b2c3d4, 32'h1001, 4'b0010, 32'hd4d4d4d4, 3'b000);
    mem_row(0, 0, 1, 32'h1002, 32'ha1b2c3d4, 32'h1002, 4'b0100, 32'hd4d4d4d4, 3'b000);
    mem_row(0, 0, 1, 32'h1003, 32'ha1b2c3d4, 32'h1003, 4'b1000, 32'hd4d4d4d4, 3'b000);
    mem_row(0, 1, 1, 32'h1004, 32'ha1b2c3d4, 32'h1004, 4'b0011, 32'hc3d4c3d4, 3'b000);
    mem_row(0, 1, 1, 32'h1006, 32'ha1b2c3d4, 32'h1006, 4'b1100, 32'hc3d4c3d4, 3'b000);
    mem_row(0, 2, 1, 32'h1008, 32'ha1b2c3d4, 32'h1008, 4'b1111, 32'ha1b2c3d4, 3'b000);
    mem_row(0, 2, 0, 32'h100c, 32'h0, 32'h100c, 4'b1111, 32'h0, 3'b000);
    mem_row(0, 0, 0, 32'h100f, 32'h0, 32'h100f, 4'b1000, 32'h0, 3'b000);
    mem_row(1, 2, 1, 32'h80002000, 32'h11223344, 32'h00002000, 4'b1111, 32'h11223344, 3'b000);
    mem_row(2, 2, 0, 32'ha0003000, 32'h0, 32'h20003000, 4'b1111, 32'h0, 3'b000);
    mem_row(1, 2, 1, 32'ha0004000, 32'h11223344, 32'h0, 4'b0000, 32'h0, 3'b010);  // Kernel miss
    mem_row(0, 0, 1, 32'h1010, 32'h00000055, 32'h0, 4'b0000, 32'h0, 3'b001);
    mem_row(0, 2, 1, 32'h1002, 32'h0, 32'h0, 4'b0000, 32'h0, 3'b100);
    alu_row(`EXE_ALU_ADD, 0, 0, 32'h00000003, 32'h00000004, 32'h00000007);  // Passes the gate
    mem_row(0, 2, 1, 32'h1014, 32'h0, 32'h0, 4'b0000, 32'h0, 3'b001);
    mem_row(0, 1, 0, 32'h1001, 32'h0, 32'h0, 4'b0000, 32'h0, 3'b100);
    mem_row(0, 1, 0, 32'h1016, 32'h0, 32'h0, 4'b0000, 32'h0, 3'b001);
    mem_row(0, 2, 1, 32'h1018, 32'hcafef00d, 32'h1018, 4'b1111, 32'hcafef00d, 3'b000);
endtask

`endif

/* tests/exe_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "exe_consts.svh"

module exe_tb;

    localparam int PERIOD = 40;

    typedef struct {
        exe_pkg::id_to_exe_t id;
        exe_pkg::crmd_dmw_t  cd;
        exe_pkg::word_t      result;
        exe_pkg::word_t      addr;
        logic [3:0]          wstrb;
        exe_pkg::word_t      wdata;
        logic [1:0]          size;
        logic                ale;
        logic                tlbr;
        logic                req;
        logic                skip;  // Stuck behind an exception until flush
    } row_t;

    logic                 clk;
    logic                 reset;
    logic                 id_valid;
    exe_pkg::id_to_exe_t  id_bus;
    logic                 exe_allowin;
    logic                 mem_allowin;
    logic                 exe_to_mem_valid;
    exe_pkg::exe_to_mem_t mem_bus;
    logic                 data_req;
    exe_pkg::data_cmd_t   data_cmd;
    logic                 data_addr_ok;
    exe_pkg::crmd_dmw_t   crmd_dmw;
    logic                 exe_valid;
    logic                 exec_flush;

    row_t        rows[$];
    logic [31:0] rng;
    logic        req_seen = 1'b0;
    logic        flushed = 1'b0;
    int          n_in = 0;
    int          n_out = 0;
    int          hold = 0;
    int          errors = 0;
    int          row_err = 0;
    int          passed = 0;
    int          failed = 0;
    int          skipped = 0;
    int          cycles = 0;

    exe_stage dut0 (
        .clk              (clk),
        .reset            (reset),
        .id_valid         (id_valid),
        .id_bus           (id_bus),
        .exe_allowin      (exe_allowin),
        .mem_allowin      (mem_allowin),
        .exe_to_mem_valid (exe_to_mem_valid),
        .mem_bus          (mem_bus),
        .data_req         (data_req),
        .data_cmd         (data_cmd),
        .data_addr_ok     (data_addr_ok),
        .crmd_dmw         (crmd_dmw),
        .exe_valid        (exe_valid),
        .exec_flush       (exec_flush)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
            row_err++;
        end
    endtask

    // Mode 0 direct, 1 mapped at kernel level, 2 mapped at user level
    function automatic exe_pkg::crmd_dmw_t crmd_of(input int mode);
        exe_pkg::crmd_dmw_t c;
        c = '0;
        c.da = (mode == 0);
        c.pg = (mode != 0);
        c.plv = (mode == 2) ? exe_pkg::plv_t'(`EXE_PLV_USER) : exe_pkg::plv_t'(`EXE_PLV_KERNEL);
        c.dmw0 = {1'b1, 1'b0, 2'd1, 3'd0, 3'd4};  // Kernel window maps 0x8 to 0x0
        c.dmw1 = {1'b0, 1'b1, 2'd1, 3'd1, 3'd5};  // User window maps 0xa to 0x2
        return c;
    endfunction

    task automatic alu_row(input int op, input int a_pc, input int b_imm,
                           input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp);
        row_t r;
        r.id = '0;
        r.id.pc = (a_pc != 0) ? a : ~a;  // Unselected operand holds a decoy
        r.id.rj_value = (a_pc != 0) ? ~a : a;
        r.id.imm = (b_imm != 0) ? b : ~b;
        r.id.rkd_value = (b_imm != 0) ? ~b : b;
        r.id.alu_op = exe_pkg::alu_op_t'(1) << op;
        r.id.src1_is_pc = (a_pc != 0);
        r.id.src2_is_imm = (b_imm != 0);
        r.id.gr_we = 1'b1;
        r.id.dest = exe_pkg::reg_idx_t'(rows.size() + 1);
        r.cd = crmd_of(0);
        r.result = exp;
        r.addr = '0;
        r.wstrb = '0;
        r.wdata = '0;
        r.size = '0;
        r.ale = 1'b0;
        r.tlbr = 1'b0;
        r.req = 1'b0;
        r.skip = 1'b0;
        rows.push_back(r);
    endtask

    task automatic mem_row(input int mode, input int size, input int store,
                           input logic [31:0] vaddr, input logic [31:0] rkd,
                           input logic [31:0] paddr, input logic [3:0] strb,
                           input logic [31:0] wdata, input logic [2:0] flags);
        row_t r;
        r.id = '0;
        r.id.pc = 32'h1c000000 + 32'(rows.size() * 4);
        r.id.rj_value = vaddr & 32'hffff_fff0;  // Base plus small offset
        r.id.imm = vaddr & 32'h0000_000f;
        r.id.rkd_value = rkd;
        r.id.alu_op = exe_pkg::alu_op_t'(1) << `EXE_ALU_ADD;
        r.id.src2_is_imm = 1'b1;
        r.id.mem_we = (store != 0);
        r.id.res_from_mem = (store == 0);
        r.id.gr_we = (store == 0);
        r.id.op_b = (size == 0);
        r.id.op_h = (size == 1);
        r.id.dest = 5'd4;
        r.cd = crmd_of(mode);
        r.result = vaddr;
        r.addr = paddr;
        r.wstrb = strb;
        r.wdata = wdata;
        r.size = 2'(size);
        r.ale = flags[2];
        r.tlbr = flags[1];
        r.skip = flags[0];
        r.req = ~flags[2] & ~flags[1] & ~flags[0];
        rows.push_back(r);
    endtask

    `include "exe_tb_table.svh"

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * rows.size() + 100) begin
            $display("Timeout after %0d cycles, %0d of %0d rows done",
                     cycles, n_out, rows.size());
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        id_valid = 1'b0;
        id_bus = '0;
        mem_allowin = 1'b0;
        data_addr_ok = 1'b0;
        crmd_dmw = '0;
        exec_flush = 1'b0;
        rng = 32'h722a47c9;
        build_table();
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        check("exe_to_mem_valid", 32'(exe_to_mem_valid), 32'd0);
        check("data_req", 32'(data_req), 32'd0);
        check("exe_allowin", 32'(exe_allowin), 32'd1);
        $display("reset state %s", (row_err == 0) ? "ok" : "wrong");
        row_err = 0;
        while (n_out < rows.size()) begin
            @(posedge clk);
            #2;
            rng = xorshift(rng);
            mem_allowin = (rng[1:0] != 2'b00) && (hold != 1);  // Held during flush
            data_addr_ok = rng[9:8] != 2'b00;
            exec_flush = (hold == 1);
            crmd_dmw = rows[n_out].cd;
            id_valid = (hold == 0) && (n_in < rows.size());
            if (id_valid) begin
                id_bus = rows[n_in].id;
            end
            @(negedge clk);
            if (hold > 1) begin
                check("data_req", 32'(data_req), 32'd0);
                check("exe_to_mem_valid", 32'(exe_to_mem_valid), 32'd0);
                hold--;
            end
            if (data_req && !mem_allowin) begin
                $display("ERROR at %0t: data_req raised while mem_allowin is low", $time);
                errors++;
                row_err++;
            end
            if (!data_req) begin
                check("data_cmd.wstrb", 32'(data_cmd.wstrb), 32'd0);
            end
            if (data_req && data_addr_ok) begin
                check("data_cmd.addr", data_cmd.addr, rows[n_out].addr);
                check("data_cmd.wstrb", 32'(data_cmd.wstrb), 32'(rows[n_out].wstrb));
                check("data_cmd.wdata", data_cmd.wdata, rows[n_out].wdata);
                check("data_cmd.size", 32'(data_cmd.size), 32'(rows[n_out].size));
                check("data_cmd.wr", 32'(data_cmd.wr), 32'(rows[n_out].id.mem_we));
                req_seen = 1'b1;
            end
            if (flushed) begin
                check("exe_valid", 32'(exe_valid), 32'd0);  // Cleared by the flush edge
                flushed = 1'b0;
            end
            if (exec_flush) begin
                $display("row %0d removed by flush", n_out);
                n_out++;
                skipped++;
                hold = 0;
                flushed = 1'b1;
                req_seen = 1'b0;
                row_err = 0;
            end else if (exe_to_mem_valid && mem_allowin) begin
                check("mem_bus.pc", mem_bus.pc, rows[n_out].id.pc);
                check("mem_bus.result", mem_bus.result, rows[n_out].result);
                check("mem_bus.dest", 32'(mem_bus.dest), 32'(rows[n_out].id.dest));
                check("mem_bus.gr_we", 32'(mem_bus.gr_we), 32'(rows[n_out].id.gr_we));
                check("mem_bus.res_from_mem", 32'(mem_bus.res_from_mem),
                      32'(rows[n_out].id.res_from_mem));
                check("mem_bus.mem_we", 32'(mem_bus.mem_we), 32'(rows[n_out].id.mem_we));
                check("mem_bus.op_b", 32'(mem_bus.op_b), 32'(rows[n_out].id.op_b));
                check("mem_bus.op_h", 32'(mem_bus.op_h), 32'(rows[n_out].id.op_h));
                check("mem_bus.op_unsigned_ld", 32'(mem_bus.op_unsigned_ld),
                      32'(rows[n_out].id.op_unsigned_ld));
                check("mem_bus.vaddr_lo", 32'(mem_bus.vaddr_lo), 32'(rows[n_out].result[1:0]));
                check("mem_bus.ex_adef", 32'(mem_bus.ex_adef), 32'(rows[n_out].id.ex_adef));
                check("mem_bus.ex_ale", 32'(mem_bus.ex_ale), 32'(rows[n_out].ale));
                check("mem_bus.ex_tlbr", 32'(mem_bus.ex_tlbr), 32'(rows[n_out].tlbr));
                check("mem_bus.ex_baddr", mem_bus.ex_baddr, rows[n_out].result);
                check("data_req", 32'(req_seen), 32'(rows[n_out].req));
                $display("row %0d pc %h %s", n_out, mem_bus.pc,
                         (row_err == 0) ? "ok" : "mismatch");
                if (row_err == 0) begin
                    passed++;
                end else begin
                    failed++;
                end
                row_err = 0;
                req_seen = 1'b0;
                n_out++;
            end
            if (id_valid && exe_allowin) begin
                if (rows[n_in].skip) begin
                    hold = 5;
                end
                n_in++;
            end
        end
        $display("%0d rows ok, %0d with errors, %0d flushed, %0d errors in total",
                 passed, failed, skipped, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/exe_addr_xlate.sv */
`timescale 1ns/1ps
`default_nettype none
`include "exe_consts.svh"

module exe_addr_xlate (
    input  wire exe_pkg::word_t     vaddr,
    input  wire exe_pkg::crmd_dmw_t crmd_dmw,
    output exe_pkg::word_t          paddr,
    output logic                    tlb_miss
);

    exe_pkg::seg_t seg;
    logic          hit0;
    logic          hit1;

    function automatic logic win_hit(input exe_pkg::dmw_t w, input exe_pkg::plv_t plv,
                                     input exe_pkg::seg_t s);
        logic plv_ok;
        plv_ok = (plv == exe_pkg::plv_t'(`EXE_PLV_KERNEL) && w.plv0)
               | (plv == exe_pkg::plv_t'(`EXE_PLV_USER) && w.plv3);
        return plv_ok && (s == w.vseg);
    endfunction

    assign seg  = vaddr[31:`EXE_SEG_LSB];
    assign hit0 = ~crmd_dmw.da & win_hit(crmd_dmw.dmw0, crmd_dmw.plv, seg);
    assign hit1 = ~crmd_dmw.da & win_hit(crmd_dmw.dmw1, crmd_dmw.plv, seg) & ~hit0;

    // No TLB entries, so any mapped access outside the windows misses
    assign tlb_miss = ~crmd_dmw.da & ~hit0 & ~hit1;

    always_comb begin
        if (crmd_dmw.da) begin
            paddr = vaddr;
        end else if (hit0) begin
            paddr = {crmd_dmw.dmw0.pseg, vaddr[`EXE_SEG_LSB-1:0]};
        end else if (hit1) begin
            paddr = {crmd_dmw.dmw1.pseg, vaddr[`EXE_SEG_LSB-1:0]};
        end else begin
            paddr = '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/exe_alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "exe_consts.svh"

module exe_alu (
    input  wire exe_pkg::id_to_exe_t inst,
    output exe_pkg::word_t           alu_result
);

    exe_pkg::alu_op_t op;
    exe_pkg::word_t   src1;
    exe_pkg::word_t   src2;
    exe_pkg::word_t   adder_b;
    exe_pkg::word_t   add_result;
    exe_pkg::word_t   slt_result;
    exe_pkg::word_t   sltu_result;
    exe_pkg::word_t   sll_result;
    exe_pkg::word_t   srl_result;
    exe_pkg::word_t   sra_result;
    logic             adder_cin;
    logic             adder_cout;
    logic [4:0]       shamt;

    assign op   = inst.alu_op;
    assign src1 = inst.src1_is_pc  ? inst.pc  : inst.rj_value;
    assign src2 = inst.src2_is_imm ? inst.imm : inst.rkd_value;

    // Shared adder, subtracts for sub and both compares
    assign adder_cin = op[`EXE_ALU_SUB] | op[`EXE_ALU_SLT] | op[`EXE_ALU_SLTU];
    assign adder_b   = adder_cin ? ~src2 : src2;
    assign {adder_cout, add_result} = {1'b0, src1} + {1'b0, adder_b} + {32'd0, adder_cin};

    assign slt_result  = {31'd0, (src1[31] & ~src2[31])
                               | (~(src1[31] ^ src2[31]) & add_result[31])};
    assign sltu_result = {31'd0, ~adder_cout};  // Borrow out

    assign shamt      = src2[4:0];
    assign sll_result = src1 << shamt;
    assign srl_result = src1 >> shamt;
    assign sra_result = $signed(src1) >>> shamt;

    assign alu_result =
          ({32{op[`EXE_ALU_ADD] | op[`EXE_ALU_SUB]}} & add_result)
        | ({32{op[`EXE_ALU_SLT]}}  & slt_result)
        | ({32{op[`EXE_ALU_SLTU]}} & sltu_result)
        | ({32{op[`EXE_ALU_AND]}}  & (src1 & src2))
        | ({32{op[`EXE_ALU_NOR]}}  & ~(src1 | src2))
        | ({32{op[`EXE_ALU_OR]}}   & (src1 | src2))
        | ({32{op[`EXE_ALU_XOR]}}  & (src1 ^ src2))
        | ({32{op[`EXE_ALU_SLL]}}  & sll_result)
        | ({32{op[`EXE_ALU_SRL]}}  & srl_result)
        | ({32{op[`EXE_ALU_SRA]}}  & sra_result)
        | ({32{op[`EXE_ALU_LUI]}}  & src2);  // Immediate already shifted by decode

endmodule

`default_nettype wire

/* verilog/exe_consts.svh */
`ifndef EXE_CONSTS_SVH
`define EXE_CONSTS_SVH

// One-hot ALU operation bit positions
`define EXE_ALU_ADD     0
`define EXE_ALU_SUB     1
`define EXE_ALU_SLT     2
`define EXE_ALU_SLTU    3
`define EXE_ALU_AND     4
`define EXE_ALU_NOR     5
`define EXE_ALU_OR      6
`define EXE_ALU_XOR     7
`define EXE_ALU_SLL     8
`define EXE_ALU_SRL     9
`define EXE_ALU_SRA     10
`define EXE_ALU_LUI     11

`define EXE_SEG_LSB     29  // Lowest bit of vaddr[31:29]

`define EXE_PLV_KERNEL  0
`define EXE_PLV_USER    3

`endif

/* verilog/exe_mem_req.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_mem_req (
    input  wire exe_pkg::id_to_exe_t inst,
    input  wire                      valid,
    input  wire exe_pkg::word_t      alu_result,
    input  wire exe_pkg::word_t      paddr,
    input  wire                      tlb_miss,
    input  wire                      pre_ex,
    input  wire                      cancel,
    input  wire                      mem_allowin,
    input  wire                      data_addr_ok,
    input  wire                      exec_flush,
    output logic                     data_req,
    output exe_pkg::data_cmd_t       data_cmd,
    output logic                     has_ex,
    output logic                     mem_ready,
    output exe_pkg::exe_to_mem_t     mem_bus
);

    logic [1:0] lo;
    logic [3:0] strb;
    logic       is_ls;
    logic       op_w;
    logic       ex_ale;
    logic       ex_tlbr;

    assign lo    = alu_result[1:0];
    assign is_ls = inst.mem_we | inst.res_from_mem;
    assign op_w  = ~inst.op_b & ~inst.op_h;

    assign ex_ale  = is_ls & ((op_w & (lo != 2'b00)) | (inst.op_h & lo[0])) & ~inst.ex_adef;
    assign ex_tlbr = is_ls & tlb_miss & ~ex_ale & ~inst.ex_adef;
    assign has_ex  = inst.ex_adef | ex_ale | ex_tlbr;

    assign data_req  = is_ls & valid & ~cancel & ~pre_ex & ~has_ex & mem_allowin;
    assign mem_ready = (data_req & data_addr_ok) | has_ex | exec_flush;

    always_comb begin
        if (inst.op_b) begin
            strb = 4'b0001 << lo;
        end else if (inst.op_h) begin
            strb = lo[1] ? 4'b1100 : 4'b0011;
        end else begin
            strb = 4'b1111;
        end
    end

    assign data_cmd.wr    = inst.mem_we & ~inst.res_from_mem;
    assign data_cmd.size  = {op_w, inst.op_h};
    assign data_cmd.wstrb = strb & {4{data_req}};  // Quiet when no request
    assign data_cmd.addr  = paddr;
    assign data_cmd.wdata = inst.op_b ? {4{inst.rkd_value[7:0]}}  :
                            inst.op_h ? {2{inst.rkd_value[15:0]}} :
                                        inst.rkd_value;

    assign mem_bus.pc             = inst.pc;
    assign mem_bus.result         = alu_result;
    assign mem_bus.dest           = inst.dest;
    assign mem_bus.gr_we          = inst.gr_we;
    assign mem_bus.res_from_mem   = inst.res_from_mem;
    assign mem_bus.mem_we         = inst.mem_we;
    assign mem_bus.op_b           = inst.op_b;
    assign mem_bus.op_h           = inst.op_h;
    assign mem_bus.op_unsigned_ld = inst.op_unsigned_ld;
    assign mem_bus.vaddr_lo       = lo;
    assign mem_bus.ex_adef        = inst.ex_adef;
    assign mem_bus.ex_ale         = ex_ale;
    assign mem_bus.ex_tlbr        = ex_tlbr;
    assign mem_bus.ex_baddr       = alu_result;  // Virtual address for BADV

endmodule

`default_nettype wire

/* verilog/exe_pipe_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_pipe_ctrl (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       id_valid,
    input  wire exe_pkg::id_to_exe_t  id_bus,
    input  wire                       mem_allowin,
    input  wire                       mem_ready,
    input  wire                       has_ex,
    input  wire                       exec_flush,
    output logic                      exe_allowin,
    output exe_pkg::id_to_exe_t       inst,
    output logic                      valid,
    output logic                      ready_go,
    output logic                      exe_to_mem_valid,
    output logic                      pre_ex,
    output logic                      cancel
);

    logic is_ls;

    assign is_ls            = inst.mem_we | inst.res_from_mem;
    assign ready_go         = is_ls ? mem_ready : 1'b1;  // Memory ops wait for address accept
    assign exe_allowin      = ~valid | (ready_go & mem_allowin);
    assign exe_to_mem_valid = valid & ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (exec_flush) begin
            valid <= 1'b0;
        end else if (exe_allowin) begin
            valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_allowin && id_valid) begin
            inst <= id_bus;
        end
    end

    // Blocks further requests until the exception is taken
    always_ff @(posedge clk) begin
        if (reset) begin
            pre_ex <= 1'b0;
        end else if (~exec_flush & has_ex & valid) begin
            pre_ex <= 1'b1;
        end else if (exec_flush) begin
            pre_ex <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cancel <= 1'b0;
        end else if (exec_flush) begin
            cancel <= 1'b1;
        end else if (id_valid & exe_allowin) begin
            cancel <= 1'b0;  // New instruction after flush
        end
    end

endmodule

`default_nettype wire

/* verilog/exe_pkg.sv */
`default_nettype none

package exe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] alu_op_t;  // One-hot
    typedef logic [1:0]  plv_t;
    typedef logic [2:0]  seg_t;

    typedef struct packed {
        logic       plv0;   // Enabled at kernel level
        logic       plv3;   // Enabled at user level
        logic [1:0] mat;
        seg_t       pseg;
        seg_t       vseg;
    } dmw_t;

    typedef struct packed {
        logic da;
        logic pg;
        plv_t plv;
        dmw_t dmw0;
        dmw_t dmw1;
    } crmd_dmw_t;

    typedef struct packed {
        word_t    pc;
        word_t    rj_value;
        word_t    rkd_value;
        word_t    imm;
        alu_op_t  alu_op;
        logic     src1_is_pc;
        logic     src2_is_imm;
        logic     res_from_mem;
        logic     gr_we;
        logic     mem_we;
        logic     op_b;
        logic     op_h;
        logic     op_unsigned_ld;
        reg_idx_t dest;
        logic     ex_adef;       // From fetch
    } id_to_exe_t;

    typedef struct packed {
        word_t      pc;
        word_t      result;
        reg_idx_t   dest;
        logic       gr_we;
        logic       res_from_mem;
        logic       mem_we;
        logic       op_b;
        logic       op_h;
        logic       op_unsigned_ld;
        logic [1:0] vaddr_lo;   // Load byte lane select
        logic       ex_adef;
        logic       ex_ale;
        logic       ex_tlbr;
        word_t      ex_baddr;
    } exe_to_mem_t;

    typedef struct packed {
        logic       wr;
        logic [1:0] size;   // 0 byte, 1 half, 2 word
        logic [3:0] wstrb;
        word_t      addr;
        word_t      wdata;
    } data_cmd_t;

endpackage

`default_nettype wire

/* verilog/exe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      id_valid,
    input  wire exe_pkg::id_to_exe_t id_bus,
    output wire                      exe_allowin,
    input  wire                      mem_allowin,
    output wire                      exe_to_mem_valid,
    output wire exe_pkg::exe_to_mem_t mem_bus,
    output wire                      data_req,
    output wire exe_pkg::data_cmd_t  data_cmd,
    input  wire                      data_addr_ok,
    input  wire exe_pkg::crmd_dmw_t  crmd_dmw,
    output wire                      exe_valid,
    input  wire                      exec_flush
);

    exe_pkg::id_to_exe_t inst;
    exe_pkg::word_t      alu_result;
    exe_pkg::word_t      paddr;
    logic                valid;
    logic                cancel;
    logic                pre_ex;
    logic                tlb_miss;
    logic                has_ex;
    logic                mem_ready;

    assign exe_valid = valid;

    exe_pipe_ctrl u_pipe_ctrl (
        .clk              (clk),
        .reset            (reset),
        .id_valid         (id_valid),
        .id_bus           (id_bus),
        .mem_allowin      (mem_allowin),
        .mem_ready        (mem_ready),
        .has_ex           (has_ex),
        .exec_flush       (exec_flush),
        .exe_allowin      (exe_allowin),
        .inst             (inst),
        .valid            (valid),
        .ready_go         (),           // Only needed inside the handshake
        .exe_to_mem_valid (exe_to_mem_valid),
        .pre_ex           (pre_ex),
        .cancel           (cancel)
    );

    exe_alu u_alu (
        .inst       (inst),
        .alu_result (alu_result)
    );

    exe_addr_xlate u_addr_xlate (
        .vaddr    (alu_result),
        .crmd_dmw (crmd_dmw),
        .paddr    (paddr),
        .tlb_miss (tlb_miss)
    );

    exe_mem_req u_mem_req (
        .inst         (inst),
        .valid        (valid),
        .alu_result   (alu_result),
        .paddr        (paddr),
        .tlb_miss     (tlb_miss),
        .pre_ex       (pre_ex),
        .cancel       (cancel),
        .mem_allowin  (mem_allowin),
        .data_addr_ok (data_addr_ok),
        .exec_flush   (exec_flush),
        .data_req     (data_req),
        .data_cmd     (data_cmd),
        .has_ex       (has_ex),
        .mem_ready    (mem_ready),
        .mem_bus      (mem_bus)
    );

endmodule

`default_nettype wire
